// File: Bender.yml
package:
  name: nf_10g_if_regs

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/nf_if_pkg.sv
      - common/reg_bus_if.sv
      - hdl/pkt_counter.sv
      - cpu_regs/axil_reg_slave.sv
      - cpu_regs/if_reg_bank.sv
      - hdl/nf_10g_if_regs.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_nf_10g_if_regs.sv

// File: common/nf_if_macros.svh
// Register widths, defaults, block ID, counter width and reset-register bit positions
`ifndef NF_IF_MACROS_SVH
`define NF_IF_MACROS_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

// Register word and AXI4-Lite data width
`define NF_IF_DATA_WIDTH 32

// AXI4-Lite byte address width
`define NF_IF_ADDR_WIDTH 12

////////////////////////////////////////////////////////////
// Register contents
////////////////////////////////////////////////////////////

// Low half of the ID word
`define NF_IF_BLOCK_ID 16'h1001

`define NF_IF_VERSION 32'h0001_0000

// Added to the stored debug value on every read
`define NF_IF_DEBUG_DEFAULT 32'h0000_00a5

// Packet counter width, top bit is the sticky overflow flag
`define NF_IF_PKT_CNT_WIDTH 32

// Reset register bits
`define NF_IF_RST_CLEAR_BIT 0
`define NF_IF_RST_REGS_BIT 4

`endif

// File: common/nf_if_pkg.sv
// Register word, address, offset and AXI response types
`include "nf_if_macros.svh"

package nf_if_pkg;

  ////////////////////////////////////////////////////////////
  // Register bus words
  ////////////////////////////////////////////////////////////

  // One full register word, writes are always full words
  typedef logic [`NF_IF_DATA_WIDTH-1:0] reg_word_t;

  // Byte address as seen on the AXI4-Lite bus
  typedef logic [`NF_IF_ADDR_WIDTH-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  typedef enum reg_addr_t {
    OFF_ID      = 12'h000,
    OFF_VERSION = 12'h004,
    OFF_RESET   = 12'h008,
    OFF_FLIP    = 12'h00c,
    OFF_DEBUG   = 12'h010,
    OFF_IFID    = 12'h014,
    OFF_PKTIN   = 12'h018,
    OFF_PKTOUT  = 12'h01c,
    OFF_MACSTAT = 12'h020,
    OFF_PCSSTAT = 12'h024
  } reg_offset_e;

  // AXI4-Lite response codes, the slave only ever answers OKAY
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axil_resp_t;

endpackage

// File: common/reg_bus_if.sv
// Single-cycle register access bus between the AXI4-Lite slave and the register bank
`timescale 1ns/10ps

interface reg_bus_if;

  import nf_if_pkg::*;

  // One-cycle strobes, never high together
  logic wr_en;
  logic rd_en;

  // Byte address and write word, valid with the strobes
  reg_addr_t addr;
  reg_word_t wdata;

  // Registered read word, valid the cycle after rd_en
  reg_word_t rdata;

  // Side that starts accesses
  modport ctrl (
    output wr_en,
    output rd_en,
    output addr,
    output wdata,
    input  rdata
  );

  // Side that holds the registers
  modport bank (
    input  wr_en,
    input  rd_en,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: cpu_regs/axil_reg_slave.sv
// AXI4-Lite slave FSM that turns bus transactions into register bus strobes
`timescale 1ns/10ps

module axil_reg_slave (
  input  logic                   core_clk,
  input  logic                   reset,
  // Write address and data channels
  input  nf_if_pkg::reg_addr_t   awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  nf_if_pkg::reg_word_t   wdata,
  input  logic                   wvalid,
  output logic                   wready,
  // Write response channel
  output nf_if_pkg::axil_resp_t  bresp,
  output logic                   bvalid,
  input  logic                   bready,
  // Read address channel
  input  nf_if_pkg::reg_addr_t   araddr,
  input  logic                   arvalid,
  output logic                   arready,
  // Read data channel
  output nf_if_pkg::reg_word_t   rdata,
  output nf_if_pkg::axil_resp_t  rresp,
  output logic                   rvalid,
  input  logic                   rready,
  // Register side
  reg_bus_if.ctrl                bus
);

  import nf_if_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WR_RESP,
    ST_RD_WAIT,
    ST_RD_RESP
  } state_t;

  state_t state;

  ////////////////////////////////////////////////////////////
  // Transaction FSM
  ////////////////////////////////////////////////////////////

  // One transaction at a time; writes win when both arrive together
  always_ff @(posedge core_clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      awready    <= 1'b0;
      wready     <= 1'b0;
      arready    <= 1'b0;
      bvalid     <= 1'b0;
      rvalid     <= 1'b0;
      bus.wr_en  <= 1'b0;
      bus.rd_en  <= 1'b0;
    end else begin
      // Ready and strobe pulses last a single cycle
      awready   <= 1'b0;
      wready    <= 1'b0;
      arready   <= 1'b0;
      bus.wr_en <= 1'b0;
      bus.rd_en <= 1'b0;

      case (state)
        ST_IDLE: begin
          if (awvalid && wvalid) begin
            awready   <= 1'b1;
            wready    <= 1'b1;
            bus.wr_en <= 1'b1;
            state     <= ST_WR_RESP;
          end else if (arvalid) begin
            arready   <= 1'b1;
            bus.rd_en <= 1'b1;
            state     <= ST_RD_WAIT;
          end
        end

        ST_WR_RESP: begin
          // Raise bvalid the cycle after the handshake, then wait for bready
          if (!bvalid) begin
            bvalid <= 1'b1;
          end else if (bready) begin
            bvalid <= 1'b0;
            state  <= ST_IDLE;
          end
        end

        ST_RD_WAIT: begin
          // Bank word lands together with rvalid
          rvalid <= 1'b1;
          state  <= ST_RD_RESP;
        end

        ST_RD_RESP: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= ST_IDLE;
          end
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and write data capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge core_clk) begin
    if (state == ST_IDLE) begin
      if (awvalid && wvalid) begin
        bus.addr  <= awaddr;
        bus.wdata <= wdata;
      end else if (arvalid) begin
        bus.addr  <= araddr;
      end
    end
  end

  // Bank holds its read word until the next rd_en, so it stays stable under rready low
  assign rdata = bus.rdata;

  assign bresp = RESP_OKAY;
  assign rresp = RESP_OKAY;

endmodule

// File: cpu_regs/if_reg_bank.sv
// Register bank with reset register, flip, debug, ID words, status capture and read mux
`timescale 1ns/10ps
`include "nf_if_macros.svh"

module if_reg_bank (
  input  logic                  core_clk,
  input  logic                  reset,
  reg_bus_if.bank               bus,
  input  logic [7:0]            interface_number,
  input  logic [1:0]            mac_status,
  input  logic [7:0]            pcspma_status,
  input  nf_if_pkg::reg_word_t  rx_count,
  input  nf_if_pkg::reg_word_t  tx_count,
  output logic                  rx_clear,
  output logic                  tx_clear
);

  import nf_if_pkg::*;

  // Self-clearing reset register bits
  logic rst_clear_q;
  logic rst_regs_q;

  // Software written values
  reg_word_t flip_q;
  reg_word_t debug_q;

  // Sampled status
  logic [1:0] mac_q;
  logic [7:0] pcs_q;

  logic      wr_reset;
  reg_word_t rd_word;

  assign wr_reset = bus.wr_en && (bus.addr == OFF_RESET);

  ////////////////////////////////////////////////////////////
  // Reset register and written values
  ////////////////////////////////////////////////////////////

  always_ff @(posedge core_clk) begin
    if (reset) begin
      rst_clear_q <= 1'b0;
      rst_regs_q  <= 1'b0;
    end else begin
      // High for one cycle after the write, reads back as zero
      rst_clear_q <= wr_reset && bus.wdata[`NF_IF_RST_CLEAR_BIT];
      rst_regs_q  <= wr_reset && bus.wdata[`NF_IF_RST_REGS_BIT];
    end
  end

  always_ff @(posedge core_clk) begin
    if (reset || rst_regs_q) begin
      flip_q  <= '0;
      debug_q <= '0;
    end else if (bus.wr_en) begin
      if (bus.addr == OFF_FLIP) begin
        flip_q <= bus.wdata;
      end
      if (bus.addr == OFF_DEBUG) begin
        debug_q <= bus.wdata;
      end
    end
  end

  // Status inputs, one cycle of latency
  always_ff @(posedge core_clk) begin
    mac_q <= mac_status;
    pcs_q <= pcspma_status;
  end

  ////////////////////////////////////////////////////////////
  // Counter clears
  ////////////////////////////////////////////////////////////

  // Read-clear hits on the rd_en cycle, the read word still takes the old count
  assign rx_clear = rst_clear_q || rst_regs_q || (bus.rd_en && (bus.addr == OFF_PKTIN));
  assign tx_clear = rst_clear_q || rst_regs_q || (bus.rd_en && (bus.addr == OFF_PKTOUT));

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (bus.addr)
      OFF_ID:      rd_word = reg_word_t'({interface_number, `NF_IF_BLOCK_ID});
      OFF_VERSION: rd_word = `NF_IF_VERSION;
      OFF_FLIP:    rd_word = ~flip_q;
      OFF_DEBUG:   rd_word = debug_q + reg_word_t'(`NF_IF_DEBUG_DEFAULT);
      OFF_IFID:    rd_word = reg_word_t'(interface_number);
      OFF_PKTIN:   rd_word = rx_count;
      OFF_PKTOUT:  rd_word = tx_count;
      OFF_MACSTAT: rd_word = reg_word_t'(mac_q);
      OFF_PCSSTAT: rd_word = reg_word_t'(pcs_q);
      // Reset register and unmapped space
      default:     rd_word = '0;
    endcase
  end

  // Held between reads
  always_ff @(posedge core_clk) begin
    if (bus.rd_en) begin
      bus.rdata <= rd_word;
    end
  end

endmodule

// File: dv/tb_clk_gen.sv
// Free-running testbench clock with a 4 ns period
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real half_period = 2.0
) (
  output logic core_clk
);

  initial begin
    core_clk = 1'b0;
    forever begin
      #(half_period) core_clk = ~core_clk;
    end
  end

endmodule

// File: dv/tb_nf_10g_if_regs.sv
// Testbench for the port register block with AXI4-Lite tasks, stream taps and reference model
`timescale 1ns/10ps
`include "nf_if_macros.svh"

module tb_nf_10g_if_regs;

  import nf_if_pkg::*;

  localparam int cnt_w   = 5;
  localparam int cnt_mod = 2 ** (cnt_w - 1);
  localparam int limit   = 50;

  logic       core_clk;
  logic       reset;
  reg_addr_t  awaddr;
  logic       awvalid;
  logic       awready;
  reg_word_t  wdata;
  logic       wvalid;
  logic       wready;
  axil_resp_t bresp;
  logic       bvalid;
  logic       bready;
  reg_addr_t  araddr;
  logic       arvalid;
  logic       arready;
  reg_word_t  rdata;
  axil_resp_t rresp;
  logic       rvalid;
  logic       rready;
  logic       rx_tvalid;
  logic       rx_tready;
  logic       rx_tlast;
  logic       tx_tvalid;
  logic       tx_tready;
  logic       tx_tlast;
  logic [7:0] interface_number;
  logic [1:0] mac_status;
  logic [7:0] pcspma_status;

  // Model state
  integer    seed;
  reg_word_t flip_w;
  reg_word_t debug_w;
  int        rx_pkts;
  int        tx_pkts;
  int        n_rx;
  int        n_tx;

  // Reads waiting for the compare process
  reg_word_t  got_q[$];
  reg_word_t  exp_q[$];
  axil_resp_t resp_q[$];
  reg_addr_t  addr_q[$];

  int error_count;
  int check_count;
  int tests_run;
  int tests_failed;
  int test_base;

  tb_clk_gen u_clk (.core_clk(core_clk));

  nf_10g_if_regs #(
    .cnt_width (cnt_w)
  ) u_dut (.*);

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic reg_word_t expected_value(
    input reg_addr_t  off,
    input reg_word_t  f_val,
    input reg_word_t  d_val,
    input int         rx_cnt,
    input logic       rx_sticky,
    input int         tx_cnt,
    input logic       tx_sticky,
    input logic [1:0] mac,
    input logic [7:0] pcs,
    input logic [7:0] ifnum
  );
    case (off)
      OFF_ID:      return {8'h00, ifnum, `NF_IF_BLOCK_ID};
      OFF_VERSION: return `NF_IF_VERSION;
      OFF_FLIP:    return ~f_val;
      OFF_DEBUG:   return d_val + `NF_IF_DEBUG_DEFAULT;
      OFF_IFID:    return {24'h0, ifnum};
      OFF_PKTIN:   return (reg_word_t'(rx_sticky) << (cnt_w - 1)) + reg_word_t'(rx_cnt);
      OFF_PKTOUT:  return (reg_word_t'(tx_sticky) << (cnt_w - 1)) + reg_word_t'(tx_cnt);
      OFF_MACSTAT: return {30'h0, mac};
      OFF_PCSSTAT: return {24'h0, pcs};
      default:     return '0;
    endcase
  endfunction

  // Compare process, drains the read queue on every clock edge
  always @(posedge core_clk) begin : compare_reads
    reg_word_t  got_word;
    reg_word_t  exp_word;
    axil_resp_t resp;
    reg_addr_t  addr;
    while (got_q.size() > 0) begin
      got_word = got_q.pop_front();
      exp_word = exp_q.pop_front();
      resp     = resp_q.pop_front();
      addr     = addr_q.pop_front();
      check_count++;
      assert (got_word == exp_word) else begin
        $display("FAILED %0t: read of 0x%03h returned 0x%08h, expected 0x%08h",
                 $time, addr, got_word, exp_word);
        error_count++;
      end
      assert (resp == RESP_OKAY) else begin
        $display("FAILED %0t: read of 0x%03h answered rresp %0d", $time, addr, resp);
        error_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $finish;
  endtask

  task automatic axil_write(input reg_addr_t addr, input reg_word_t data, input int stall);
    int wait_cnt;
    @(posedge core_clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_cnt = 0;
    @(posedge core_clk);
    #1;
    while (!awready && wait_cnt < limit) begin
      @(posedge core_clk);
      #1;
      wait_cnt++;
    end
    if (!awready) abort_run("Timeout waiting for awready on a write");
    assert (wready) else begin
      $display("wready did not pulse together with awready at %0t", $time);
      error_count++;
    end
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    wait_cnt = 0;
    while (!bvalid && wait_cnt < limit) begin
      @(posedge core_clk);
      #1;
      wait_cnt++;
    end
    if (!bvalid) abort_run("Timeout waiting for bvalid on a write");
    // Back-pressure on the response channel
    repeat (stall) begin
      @(posedge core_clk);
      #1;
      assert (bvalid) else begin
        $display("bvalid dropped while bready was held low at %0t", $time);
        error_count++;
      end
    end
    assert (bresp == RESP_OKAY) else begin
      $display("FAILED %0t: write to 0x%03h answered bresp %0d", $time, addr, bresp);
      error_count++;
    end
    bready = 1'b1;
    @(posedge core_clk);
    #1;
    bready = 1'b0;
    assert (!bvalid) else begin
      $display("bvalid stayed high after the response was accepted at %0t", $time);
      error_count++;
    end
  endtask

  task automatic axil_read(input reg_addr_t addr, input int stall,
                           output reg_word_t data, output axil_resp_t resp);
    int wait_cnt;
    @(posedge core_clk);
    #1;
    araddr   = addr;
    arvalid  = 1'b1;
    wait_cnt = 0;
    @(posedge core_clk);
    #1;
    while (!arready && wait_cnt < limit) begin
      @(posedge core_clk);
      #1;
      wait_cnt++;
    end
    if (!arready) abort_run("Timeout waiting for arready on a read");
    arvalid  = 1'b0;
    wait_cnt = 0;
    while (!rvalid && wait_cnt < limit) begin
      @(posedge core_clk);
      #1;
      wait_cnt++;
    end
    if (!rvalid) abort_run("Timeout waiting for rvalid on a read");
    data = rdata;
    resp = rresp;
    repeat (stall) begin
      @(posedge core_clk);
      #1;
      assert (rvalid && rdata == data) else begin
        $display("rvalid dropped or rdata changed while rready was held low at %0t", $time);
        error_count++;
      end
    end
    rready = 1'b1;
    @(posedge core_clk);
    #1;
    rready = 1'b0;
  endtask

  // Read one register and queue it against the model
  task automatic read_and_check(input reg_addr_t off, input int stall);
    reg_word_t  data;
    axil_resp_t resp;
    axil_read(off, stall, data, resp);
    got_q.push_back(data);
    resp_q.push_back(resp);
    addr_q.push_back(off);
    exp_q.push_back(expected_value(off, flip_w, debug_w,
                                   rx_pkts % cnt_mod, rx_pkts >= cnt_mod,
                                   tx_pkts % cnt_mod, tx_pkts >= cnt_mod,
                                   mac_status, pcspma_status, interface_number));
    // Read-clear counters
    if (off == OFF_PKTIN) rx_pkts = 0;
    if (off == OFF_PKTOUT) tx_pkts = 0;
  endtask

  task automatic set_tap(input logic is_rx, input logic v, input logic r, input logic l);
    if (is_rx) begin
      rx_tvalid = v;
      rx_tready = r;
      rx_tlast  = l;
    end else begin
      tx_tvalid = v;
      tx_tready = r;
      tx_tlast  = l;
    end
  endtask

  // Packets of one to three beats with random idle and stalled cycles
  task automatic send_packets(input logic is_rx, input int n);
    int beats;
    for (int p = 0; p < n; p++) begin
      beats = ($unsigned($random(seed)) % 3) + 1;
      for (int b = 0; b < beats; b++) begin
        if ($random(seed) & 1) begin
          set_tap(is_rx, 1'b0, 1'b1, 1'b1);
          @(posedge core_clk);
          #1;
        end
        if ($random(seed) & 1) begin
          set_tap(is_rx, 1'b1, 1'b0, b == beats - 1);
          @(posedge core_clk);
          #1;
        end
        set_tap(is_rx, 1'b1, 1'b1, b == beats - 1);
        @(posedge core_clk);
        #1;
      end
    end
    set_tap(is_rx, 1'b0, 1'b0, 1'b0);
    @(posedge core_clk);
    #1;
    if (is_rx) rx_pkts += n;
    else tx_pkts += n;
  endtask

  task automatic end_test(input string name);
    int wait_cnt;
    wait_cnt = 0;
    while (got_q.size() != 0 && wait_cnt < limit) begin
      @(posedge core_clk);
      #1;
      wait_cnt++;
    end
    if (got_q.size() != 0) abort_run("Compare process did not drain the read queue");
    tests_run++;
    if (error_count != test_base) begin
      tests_failed++;
      $display("Test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("Test %0d %s: PASS", tests_run, name);
    end
    test_base = error_count;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed = 32'h215f;
    reset = 1'b1;
    {awaddr, awvalid, wdata, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;
    {rx_tvalid, rx_tready, rx_tlast, tx_tvalid, tx_tready, tx_tlast} = '0;
    interface_number = $random(seed);
    mac_status = 2'b00;
    pcspma_status = 8'h00;
    {flip_w, debug_w} = '0;
    {rx_pkts, tx_pkts} = '0;
    {error_count, check_count, tests_run, tests_failed, test_base} = '0;
    repeat (10) @(posedge core_clk);
    #1;
    reset = 1'b0;

    read_and_check(OFF_ID, 0);
    read_and_check(OFF_VERSION, 0);
    read_and_check(OFF_IFID, 0);
    read_and_check(OFF_FLIP, 0);
    read_and_check(OFF_DEBUG, 0);
    end_test("reset values");

    flip_w = $random(seed);
    axil_write(OFF_FLIP, flip_w, 0);
    debug_w = $random(seed);
    axil_write(OFF_DEBUG, debug_w, 0);
    read_and_check(OFF_FLIP, 0);
    read_and_check(OFF_DEBUG, 0);
    axil_write(OFF_RESET, 32'h1 << `NF_IF_RST_REGS_BIT, 0);
    {flip_w, debug_w} = '0;
    read_and_check(OFF_FLIP, 0);
    read_and_check(OFF_DEBUG, 0);
    read_and_check(OFF_RESET, 0);
    end_test("flip and debug");

    n_rx = ($unsigned($random(seed)) % 15) + 1;
    n_tx = ($unsigned($random(seed)) % 15) + 1;
    send_packets(1'b1, n_rx);
    send_packets(1'b0, n_tx);
    read_and_check(OFF_PKTIN, 0);
    read_and_check(OFF_PKTOUT, 0);
    read_and_check(OFF_PKTIN, 0);
    read_and_check(OFF_PKTOUT, 0);
    end_test("packet counts");

    send_packets(1'b1, 20);
    read_and_check(OFF_PKTIN, 0);
    send_packets(1'b1, 3);
    send_packets(1'b0, 2);
    axil_write(OFF_RESET, 32'h1 << `NF_IF_RST_CLEAR_BIT, 0);
    {rx_pkts, tx_pkts} = '0;
    read_and_check(OFF_PKTIN, 0);
    read_and_check(OFF_PKTOUT, 0);
    end_test("counter overflow and clear");

    mac_status = $random(seed);
    pcspma_status = $random(seed);
    read_and_check(OFF_MACSTAT, 0);
    read_and_check(OFF_PCSSTAT, 0);
    read_and_check(12'h100, 0);
    end_test("status and unmapped");

    flip_w = $random(seed);
    axil_write(OFF_FLIP, flip_w, 5);
    read_and_check(OFF_FLIP, 5);
    read_and_check(OFF_ID, 4);
    end_test("response back-pressure");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: hdl/nf_10g_if_regs.sv
// Top level wiring the AXI4-Lite slave, register bank and two packet counters
`timescale 1ns/10ps
`include "nf_if_macros.svh"

module nf_10g_if_regs #(
  parameter int cnt_width = `NF_IF_PKT_CNT_WIDTH
) (
  input  logic                   core_clk,
  input  logic                   reset,
  // AXI4-Lite slave
  input  nf_if_pkg::reg_addr_t   awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  nf_if_pkg::reg_word_t   wdata,
  input  logic                   wvalid,
  output logic                   wready,
  output nf_if_pkg::axil_resp_t  bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  nf_if_pkg::reg_addr_t   araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output nf_if_pkg::reg_word_t   rdata,
  output nf_if_pkg::axil_resp_t  rresp,
  output logic                   rvalid,
  input  logic                   rready,
  // Stream taps
  input  logic                   rx_tvalid,
  input  logic                   rx_tready,
  input  logic                   rx_tlast,
  input  logic                   tx_tvalid,
  input  logic                   tx_tready,
  input  logic                   tx_tlast,
  // Port identity and status
  input  logic [7:0]             interface_number,
  input  logic [1:0]             mac_status,
  input  logic [7:0]             pcspma_status
);

  import nf_if_pkg::*;

  reg_word_t rx_count;
  reg_word_t tx_count;
  logic      rx_clear;
  logic      tx_clear;

  reg_bus_if u_reg_bus ();

  axil_reg_slave u_axil (
    .core_clk (core_clk),
    .reset    (reset),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .bus      (u_reg_bus)
  );

  if_reg_bank u_bank (
    .core_clk         (core_clk),
    .reset            (reset),
    .bus              (u_reg_bus),
    .interface_number (interface_number),
    .mac_status       (mac_status),
    .pcspma_status    (pcspma_status),
    .rx_count         (rx_count),
    .tx_count         (tx_count),
    .rx_clear         (rx_clear),
    .tx_clear         (tx_clear)
  );

  // Receive side feeds PKTIN, transmit side feeds PKTOUT
  pkt_counter #(
    .cnt_width (cnt_width)
  ) u_rx_cnt (
    .core_clk (core_clk),
    .reset    (reset),
    .tvalid   (rx_tvalid),
    .tready   (rx_tready),
    .tlast    (rx_tlast),
    .clear    (rx_clear),
    .count    (rx_count)
  );

  pkt_counter #(
    .cnt_width (cnt_width)
  ) u_tx_cnt (
    .core_clk (core_clk),
    .reset    (reset),
    .tvalid   (tx_tvalid),
    .tready   (tx_tready),
    .tlast    (tx_tlast),
    .clear    (tx_clear),
    .count    (tx_count)
  );

endmodule

// File: hdl/pkt_counter.sv
// Packet counter for one stream tap with clear and sticky overflow bit
`timescale 1ns/10ps
`include "nf_if_macros.svh"

module pkt_counter #(
  parameter int cnt_width = `NF_IF_PKT_CNT_WIDTH
) (
  input  logic                  core_clk,
  input  logic                  reset,
  input  logic                  tvalid,
  input  logic                  tready,
  input  logic                  tlast,
  input  logic                  clear,
  output nf_if_pkg::reg_word_t  count
);

  import nf_if_pkg::*;

  logic [cnt_width-2:0] cnt_q;
  logic                 sticky_q;
  logic                 pkt_done;

  // A packet ends on an accepted last beat
  assign pkt_done = tvalid && tready && tlast;

  always_ff @(posedge core_clk) begin
    if (reset || clear) begin
      // Clear wins over a packet in the same cycle
      cnt_q    <= '0;
      sticky_q <= 1'b0;
    end else if (pkt_done) begin
      cnt_q <= cnt_q + 1'b1;
      // Wrap past all ones
      if (&cnt_q) begin
        sticky_q <= 1'b1;
      end
    end
  end

  assign count = reg_word_t'({sticky_q, cnt_q});

endmodule

// File: vlog.f
+incdir+common
common/nf_if_pkg.sv
common/reg_bus_if.sv
hdl/pkt_counter.sv
cpu_regs/axil_reg_slave.sv
cpu_regs/if_reg_bank.sv
hdl/nf_10g_if_regs.sv
dv/tb_clk_gen.sv
dv/tb_nf_10g_if_regs.sv
